/* hyper_share_pkg.sv */
// Shared widths and stream types for the two-master HyperBus PHY port.
// One PHY only, so a beat is two bytes wide.
// Chip selects are one-hot and are not checked anywhere in the design.

package hyper_share_pkg;

    localparam int unsigned NUM_CHIPS  = 2;
    localparam int unsigned PHY_DATA_W = 16;
    localparam int unsigned PHY_STRB_W = PHY_DATA_W / 8;
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned BURST_W    = 16;

    // Transfer descriptor, 49 bits
    typedef struct packed {
        logic               write;
        logic [ADDR_W-1:0]  address;
        // Length in PHY beats
        logic [BURST_W-1:0] burst;
    } hyper_tf_t;

    // Descriptor with its chip select, 51 bits
    typedef struct packed {
        hyper_tf_t            trans;
        logic [NUM_CHIPS-1:0] cs;
    } trans_t;

    // Write beat, 19 bits
    typedef struct packed {
        logic [PHY_DATA_W-1:0] data;
        logic                  last;
        // Byte mask, high bit enables the byte
        logic [PHY_STRB_W-1:0] strb;
    } hyper_tx_t;

    // Read beat, 18 bits
    typedef struct packed {
        logic [PHY_DATA_W-1:0] data;
        logic                  last;
        logic                  error;
    } hyper_rx_t;

    // Master that owns the PHY
    typedef enum logic {
        OWNER_AXI  = 1'b0,
        OWNER_UDMA = 1'b1
    } owner_e;

endpackage

/* hyper_owner_arbiter.sv */
// PHY ownership for one whole transfer, decided when the descriptor is taken.
// Reads end on the accepted last rx beat, writes on the accepted b response.
// Relies on the PHY holding trans ready low while a transfer runs.
// Ties go round-robin, AXI first after reset.

`timescale 1ns/10ps

module hyper_owner_arbiter (
    input  logic                    clk_phy_i,
    input  logic                    rst_i,
    input  logic                    axi_trans_valid_i,
    input  logic                    udma_trans_valid_i,
    input  logic                    phy_trans_write_i,
    input  logic                    phy_trans_valid_i,
    input  logic                    phy_trans_ready_i,
    input  logic                    phy_rx_last_i,
    input  logic                    phy_rx_valid_i,
    input  logic                    phy_rx_ready_i,
    input  logic                    phy_b_valid_i,
    input  logic                    phy_b_ready_i,
    output hyper_share_pkg::owner_e sel_o
);

    logic                    busy_q;
    logic                    write_q;
    hyper_share_pkg::owner_e owner_q;
    hyper_share_pkg::owner_e last_win_q;
    hyper_share_pkg::owner_e cand;
    logic                    trans_fire;
    logic                    rx_fire;
    logic                    b_fire;
    logic                    tf_end;

    assign trans_fire = phy_trans_valid_i & phy_trans_ready_i;
    assign rx_fire    = phy_rx_valid_i & phy_rx_ready_i;
    assign b_fire     = phy_b_valid_i & phy_b_ready_i;

    // End handshake depends on the direction taken at start
    assign tf_end = busy_q & (write_q ? b_fire : (rx_fire & phy_rx_last_i));

    // Idle candidate
    always_comb begin
        if (axi_trans_valid_i && udma_trans_valid_i) begin
            // Both waiting: the one that lost last time
            if (last_win_q == hyper_share_pkg::OWNER_AXI) begin
                cand = hyper_share_pkg::OWNER_UDMA;
            end else begin
                cand = hyper_share_pkg::OWNER_AXI;
            end
        end else if (udma_trans_valid_i) begin
            cand = hyper_share_pkg::OWNER_UDMA;
        end else begin
            cand = hyper_share_pkg::OWNER_AXI;
        end
    end

    assign sel_o = busy_q ? owner_q : cand;

    always_ff @(posedge clk_phy_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            write_q    <= 1'b0;
            owner_q    <= hyper_share_pkg::OWNER_AXI;
            // Makes AXI win the first tie
            last_win_q <= hyper_share_pkg::OWNER_UDMA;
        end else if (!busy_q) begin
            if (trans_fire) begin
                busy_q     <= 1'b1;
                write_q    <= phy_trans_write_i;
                owner_q    <= cand;
                last_win_q <= cand;
            end
        end else if (tf_end) begin
            busy_q <= 1'b0;
        end
    end

endmodule

/* hyper_request_mux.sv */
// Descriptor and write-data multiplexers toward the PHY.
// Purely combinational; the unselected master always sees ready low.

`timescale 1ns/10ps

module hyper_request_mux (
    input  hyper_share_pkg::owner_e   sel_i,
    // AXI side
    input  hyper_share_pkg::trans_t    axi_trans_i,
    input  logic                       axi_trans_valid_i,
    output logic                       axi_trans_ready_o,
    input  hyper_share_pkg::hyper_tx_t axi_tx_i,
    input  logic                       axi_tx_valid_i,
    output logic                       axi_tx_ready_o,
    // uDMA side
    input  hyper_share_pkg::trans_t    udma_trans_i,
    input  logic                       udma_trans_valid_i,
    output logic                       udma_trans_ready_o,
    input  hyper_share_pkg::hyper_tx_t udma_tx_i,
    input  logic                       udma_tx_valid_i,
    output logic                       udma_tx_ready_o,
    // PHY side
    output hyper_share_pkg::trans_t    phy_trans_o,
    output logic                       phy_trans_valid_o,
    input  logic                       phy_trans_ready_i,
    output hyper_share_pkg::hyper_tx_t phy_tx_o,
    output logic                       phy_tx_valid_o,
    input  logic                       phy_tx_ready_i
);

    logic sel_udma;

    assign sel_udma = (sel_i == hyper_share_pkg::OWNER_UDMA);

    // Descriptor stream
    assign phy_trans_o        = sel_udma ? udma_trans_i : axi_trans_i;
    assign phy_trans_valid_o  = sel_udma ? udma_trans_valid_i : axi_trans_valid_i;
    assign axi_trans_ready_o  = ~sel_udma & phy_trans_ready_i;
    assign udma_trans_ready_o = sel_udma & phy_trans_ready_i;

    // Write data stream
    assign phy_tx_o        = sel_udma ? udma_tx_i : axi_tx_i;
    assign phy_tx_valid_o  = sel_udma ? udma_tx_valid_i : axi_tx_valid_i;
    assign axi_tx_ready_o  = ~sel_udma & phy_tx_ready_i;
    assign udma_tx_ready_o = sel_udma & phy_tx_ready_i;

endmodule

/* hyper_response_route.sv */
// Steers read beats and write responses back to the owning master.
// Purely combinational. Under uDMA ownership the PHY b response is
// accepted at once and dropped, the uDMA side has no b channel.

`timescale 1ns/10ps

module hyper_response_route (
    input  hyper_share_pkg::owner_e    sel_i,
    // PHY side
    input  hyper_share_pkg::hyper_rx_t phy_rx_i,
    input  logic                       phy_rx_valid_i,
    output logic                       phy_rx_ready_o,
    input  logic                       phy_b_error_i,
    input  logic                       phy_b_valid_i,
    output logic                       phy_b_ready_o,
    // AXI side
    output hyper_share_pkg::hyper_rx_t axi_rx_o,
    output logic                       axi_rx_valid_o,
    input  logic                       axi_rx_ready_i,
    output logic                       axi_b_error_o,
    output logic                       axi_b_valid_o,
    input  logic                       axi_b_ready_i,
    // uDMA side
    output hyper_share_pkg::hyper_rx_t udma_rx_o,
    output logic                       udma_rx_valid_o,
    input  logic                       udma_rx_ready_i
);

    logic sel_axi;

    assign sel_axi = (sel_i == hyper_share_pkg::OWNER_AXI);

    // Read data goes to both, valid only to the owner
    assign axi_rx_o        = phy_rx_i;
    assign udma_rx_o       = phy_rx_i;
    assign axi_rx_valid_o  = sel_axi & phy_rx_valid_i;
    assign udma_rx_valid_o = ~sel_axi & phy_rx_valid_i;
    assign phy_rx_ready_o  = sel_axi ? axi_rx_ready_i : udma_rx_ready_i;

    // Write response
    assign axi_b_error_o = sel_axi & phy_b_error_i;
    assign axi_b_valid_o = sel_axi & phy_b_valid_i;
    assign phy_b_ready_o = sel_axi ? axi_b_ready_i : 1'b1;

endmodule

/* hyper_phy_share.sv */
// Two masters, AXI and uDMA, sharing one HyperBus PHY port.
// Single clock domain; all data paths are combinational.
// Only ownership is registered, one transfer at a time.

`timescale 1ns/10ps

module hyper_phy_share (
    input  logic                       clk_phy_i,
    input  logic                       rst_i,
    // AXI master
    input  hyper_share_pkg::trans_t    axi_trans_i,
    input  logic                       axi_trans_valid_i,
    output logic                       axi_trans_ready_o,
    input  hyper_share_pkg::hyper_tx_t axi_tx_i,
    input  logic                       axi_tx_valid_i,
    output logic                       axi_tx_ready_o,
    output hyper_share_pkg::hyper_rx_t axi_rx_o,
    output logic                       axi_rx_valid_o,
    input  logic                       axi_rx_ready_i,
    output logic                       axi_b_error_o,
    output logic                       axi_b_valid_o,
    input  logic                       axi_b_ready_i,
    // uDMA master
    input  hyper_share_pkg::trans_t    udma_trans_i,
    input  logic                       udma_trans_valid_i,
    output logic                       udma_trans_ready_o,
    input  hyper_share_pkg::hyper_tx_t udma_tx_i,
    input  logic                       udma_tx_valid_i,
    output logic                       udma_tx_ready_o,
    output hyper_share_pkg::hyper_rx_t udma_rx_o,
    output logic                       udma_rx_valid_o,
    input  logic                       udma_rx_ready_i,
    // PHY
    output hyper_share_pkg::trans_t    phy_trans_o,
    output logic                       phy_trans_valid_o,
    input  logic                       phy_trans_ready_i,
    output hyper_share_pkg::hyper_tx_t phy_tx_o,
    output logic                       phy_tx_valid_o,
    input  logic                       phy_tx_ready_i,
    input  hyper_share_pkg::hyper_rx_t phy_rx_i,
    input  logic                       phy_rx_valid_i,
    output logic                       phy_rx_ready_o,
    input  logic                       phy_b_error_i,
    input  logic                       phy_b_valid_i,
    output logic                       phy_b_ready_o
);

    hyper_share_pkg::owner_e sel;

    hyper_owner_arbiter i_owner_arbiter (
        .clk_phy_i          ( clk_phy_i                    ),
        .rst_i              ( rst_i                        ),
        .axi_trans_valid_i  ( axi_trans_valid_i            ),
        .udma_trans_valid_i ( udma_trans_valid_i           ),
        .phy_trans_write_i  ( phy_trans_o.trans.write      ),
        .phy_trans_valid_i  ( phy_trans_valid_o            ),
        .phy_trans_ready_i  ( phy_trans_ready_i            ),
        .phy_rx_last_i      ( phy_rx_i.last                ),
        .phy_rx_valid_i     ( phy_rx_valid_i               ),
        .phy_rx_ready_i     ( phy_rx_ready_o               ),
        .phy_b_valid_i      ( phy_b_valid_i                ),
        .phy_b_ready_i      ( phy_b_ready_o                ),
        .sel_o              ( sel                          )
    );

    hyper_request_mux i_request_mux (
        .sel_i              ( sel                ),
        .axi_trans_i        ( axi_trans_i        ),
        .axi_trans_valid_i  ( axi_trans_valid_i  ),
        .axi_trans_ready_o  ( axi_trans_ready_o  ),
        .axi_tx_i           ( axi_tx_i           ),
        .axi_tx_valid_i     ( axi_tx_valid_i     ),
        .axi_tx_ready_o     ( axi_tx_ready_o     ),
        .udma_trans_i       ( udma_trans_i       ),
        .udma_trans_valid_i ( udma_trans_valid_i ),
        .udma_trans_ready_o ( udma_trans_ready_o ),
        .udma_tx_i          ( udma_tx_i          ),
        .udma_tx_valid_i    ( udma_tx_valid_i    ),
        .udma_tx_ready_o    ( udma_tx_ready_o    ),
        .phy_trans_o        ( phy_trans_o        ),
        .phy_trans_valid_o  ( phy_trans_valid_o  ),
        .phy_trans_ready_i  ( phy_trans_ready_i  ),
        .phy_tx_o           ( phy_tx_o           ),
        .phy_tx_valid_o     ( phy_tx_valid_o     ),
        .phy_tx_ready_i     ( phy_tx_ready_i     )
    );

    hyper_response_route i_response_route (
        .sel_i           ( sel             ),
        .phy_rx_i        ( phy_rx_i        ),
        .phy_rx_valid_i  ( phy_rx_valid_i  ),
        .phy_rx_ready_o  ( phy_rx_ready_o  ),
        .phy_b_error_i   ( phy_b_error_i   ),
        .phy_b_valid_i   ( phy_b_valid_i   ),
        .phy_b_ready_o   ( phy_b_ready_o   ),
        .axi_rx_o        ( axi_rx_o        ),
        .axi_rx_valid_o  ( axi_rx_valid_o  ),
        .axi_rx_ready_i  ( axi_rx_ready_i  ),
        .axi_b_error_o   ( axi_b_error_o   ),
        .axi_b_valid_o   ( axi_b_valid_o   ),
        .axi_b_ready_i   ( axi_b_ready_i   ),
        .udma_rx_o       ( udma_rx_o       ),
        .udma_rx_valid_o ( udma_rx_valid_o ),
        .udma_rx_ready_i ( udma_rx_ready_i )
    );

endmodule

/* tb_phy_model.sv */
// Simple HyperBus PHY responder for the testbench.
// One transfer at a time; trans ready stays low while it runs.
// Read beats and b error bits come from the testbench LFSR word on rnd_i.

`timescale 1ns/10ps

module tb_phy_model (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  hyper_share_pkg::trans_t    trans_i,
    input  logic                       trans_valid_i,
    output logic                       trans_ready_o,
    input  hyper_share_pkg::hyper_tx_t tx_i,
    input  logic                       tx_valid_i,
    output logic                       tx_ready_o,
    output hyper_share_pkg::hyper_rx_t rx_o,
    output logic                       rx_valid_o,
    input  logic                       rx_ready_i,
    output logic                       b_error_o,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    input  logic [16:0]                rnd_i
);

    logic                    trans_fire_q;
    logic                    rx_fire_q;
    logic                    tx_last_q;
    logic                    b_fire_q;
    hyper_share_pkg::trans_t desc_q;
    logic [15:0]             left;

    // Handshakes seen at the rising edge, acted on at the falling edge
    always @(posedge clk_i) begin
        trans_fire_q <= trans_valid_i & trans_ready_o;
        rx_fire_q    <= rx_valid_i_fire();
        tx_last_q    <= tx_valid_i & tx_ready_o & tx_i.last;
        b_fire_q     <= b_valid_o & b_ready_i;
        if (trans_valid_i && trans_ready_o) begin
            desc_q <= trans_i;
        end
    end

    function automatic logic rx_valid_i_fire();
        rx_valid_i_fire = rx_valid_o & rx_ready_i;
    endfunction

    always @(negedge clk_i) begin
        if (rst_i) begin
            trans_ready_o = 1'b1;
            tx_ready_o    = 1'b0;
            rx_o          = '0;
            rx_valid_o    = 1'b0;
            b_error_o     = 1'b0;
            b_valid_o     = 1'b0;
            left          = '0;
        end else begin
            if (trans_fire_q) begin
                trans_ready_o = 1'b0;
                if (desc_q.trans.write) begin
                    tx_ready_o = 1'b1;
                end else begin
                    // A zero burst is treated as one beat
                    left       = (desc_q.trans.burst == 0) ? 16'd1 : desc_q.trans.burst;
                    rx_o.data  = rnd_i[15:0];
                    rx_o.last  = (left == 1);
                    rx_o.error = 1'b0;
                    rx_valid_o = 1'b1;
                end
            end
            if (rx_fire_q) begin
                left = left - 1;
                if (left == 0) begin
                    rx_valid_o    = 1'b0;
                    trans_ready_o = 1'b1;
                end else begin
                    rx_o.data = rnd_i[15:0];
                    rx_o.last = (left == 1);
                end
            end
            if (tx_last_q) begin
                tx_ready_o = 1'b0;
                b_error_o  = rnd_i[16];
                b_valid_o  = 1'b1;
            end
            if (b_fire_q) begin
                b_valid_o     = 1'b0;
                trans_ready_o = 1'b1;
            end
        end
    end

endmodule

/* tb_hyper_phy_share.sv */
// Testbench for the shared PHY port with a simple PHY responder model.
// Inputs change on the falling edge; handshakes are taken at the rising edge.

`timescale 1ns/10ps

module tb_hyper_phy_share;

    localparam hyper_share_pkg::owner_e AXI  = hyper_share_pkg::OWNER_AXI;
    localparam hyper_share_pkg::owner_e UDMA = hyper_share_pkg::OWNER_UDMA;

    logic clk_phy;
    logic rst;
    hyper_share_pkg::trans_t    axi_trans, udma_trans, phy_trans, exp_axi_d, exp_udma_d;
    hyper_share_pkg::hyper_tx_t axi_tx, udma_tx, phy_tx;
    hyper_share_pkg::hyper_rx_t axi_rx, udma_rx, phy_rx;
    logic axi_trans_valid, axi_trans_ready, axi_tx_valid, axi_tx_ready;
    logic axi_rx_valid, axi_rx_ready, axi_b_error, axi_b_valid, axi_b_ready;
    logic udma_trans_valid, udma_trans_ready, udma_tx_valid, udma_tx_ready;
    logic udma_rx_valid, udma_rx_ready;
    logic phy_trans_valid, phy_trans_ready, phy_tx_valid, phy_tx_ready;
    logic phy_rx_valid, phy_rx_ready, phy_b_error, phy_b_valid, phy_b_ready;
    logic [31:0] lfsr_q;
    logic [31:0] model_bits;
    logic [16:0] rnd;
    logic axi_tf_q, udma_tf_q, axi_txf_q, udma_txf_q;
    logic tb_busy, tb_write;
    logic b_err_seen;
    hyper_share_pkg::owner_e tb_owner, last_win;
    int errors;
    int tests;

    hyper_phy_share i_hyper_phy_share (
        .clk_phy_i(clk_phy), .rst_i(rst),
        .axi_trans_i(axi_trans), .axi_trans_valid_i(axi_trans_valid),
        .axi_trans_ready_o(axi_trans_ready), .axi_tx_i(axi_tx),
        .axi_tx_valid_i(axi_tx_valid), .axi_tx_ready_o(axi_tx_ready),
        .axi_rx_o(axi_rx), .axi_rx_valid_o(axi_rx_valid), .axi_rx_ready_i(axi_rx_ready),
        .axi_b_error_o(axi_b_error), .axi_b_valid_o(axi_b_valid), .axi_b_ready_i(axi_b_ready),
        .udma_trans_i(udma_trans), .udma_trans_valid_i(udma_trans_valid),
        .udma_trans_ready_o(udma_trans_ready), .udma_tx_i(udma_tx),
        .udma_tx_valid_i(udma_tx_valid), .udma_tx_ready_o(udma_tx_ready),
        .udma_rx_o(udma_rx), .udma_rx_valid_o(udma_rx_valid), .udma_rx_ready_i(udma_rx_ready),
        .phy_trans_o(phy_trans), .phy_trans_valid_o(phy_trans_valid),
        .phy_trans_ready_i(phy_trans_ready), .phy_tx_o(phy_tx),
        .phy_tx_valid_o(phy_tx_valid), .phy_tx_ready_i(phy_tx_ready),
        .phy_rx_i(phy_rx), .phy_rx_valid_i(phy_rx_valid), .phy_rx_ready_o(phy_rx_ready),
        .phy_b_error_i(phy_b_error), .phy_b_valid_i(phy_b_valid), .phy_b_ready_o(phy_b_ready)
    );

    tb_phy_model i_phy_model (
        .clk_i(clk_phy), .rst_i(rst),
        .trans_i(phy_trans), .trans_valid_i(phy_trans_valid), .trans_ready_o(phy_trans_ready),
        .tx_i(phy_tx), .tx_valid_i(phy_tx_valid), .tx_ready_o(phy_tx_ready),
        .rx_o(phy_rx), .rx_valid_o(phy_rx_valid), .rx_ready_i(phy_rx_ready),
        .b_error_o(phy_b_error), .b_valid_o(phy_b_valid), .b_ready_i(phy_b_ready),
        .rnd_i(rnd)
    );

    always #20 clk_phy = ~clk_phy;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    always @(posedge clk_phy) begin
        take_bits(17, model_bits);
        rnd <= model_bits[16:0];
    end

    // Reference ownership tracker
    always @(posedge clk_phy) begin
        axi_tf_q   <= axi_trans_valid & axi_trans_ready;
        udma_tf_q  <= udma_trans_valid & udma_trans_ready;
        axi_txf_q  <= axi_tx_valid & axi_tx_ready;
        udma_txf_q <= udma_tx_valid & udma_tx_ready;
        if (rst) begin
            tb_busy    <= 1'b0;
            tb_write   <= 1'b0;
            tb_owner   <= AXI;
            last_win   <= UDMA;
            b_err_seen <= 1'b0;
        end else if (!tb_busy) begin
            if (phy_trans_valid && phy_trans_ready) begin
                tb_busy  <= 1'b1;
                tb_write <= phy_trans.trans.write;
                tb_owner <= (udma_trans_valid && udma_trans_ready) ? UDMA : AXI;
                last_win <= (udma_trans_valid && udma_trans_ready) ? UDMA : AXI;
            end
        end else begin
            if (tb_owner == AXI && phy_b_valid && phy_b_ready && phy_b_error) begin
                b_err_seen <= 1'b1;
            end
            if (tb_write ? (phy_b_valid && phy_b_ready)
                         : (phy_rx_valid && phy_rx_ready && phy_rx.last)) begin
                tb_busy <= 1'b0;
            end
        end
    end

    a_axi_desc: assert property (@(posedge clk_phy) disable iff (rst)
        (axi_trans_valid && axi_trans_ready) |-> phy_trans == exp_axi_d)
        else begin
            errors++;
            $display("error %0t phy_trans_o expected %h got %h", $time, exp_axi_d, phy_trans);
        end
    a_udma_desc: assert property (@(posedge clk_phy) disable iff (rst)
        (udma_trans_valid && udma_trans_ready) |-> phy_trans == exp_udma_d)
        else begin
            errors++;
            $display("error %0t phy_trans_o expected %h got %h", $time, exp_udma_d, phy_trans);
        end
    a_tx_data: assert property (@(posedge clk_phy) disable iff (rst)
        (phy_tx_valid && phy_tx_ready) |-> phy_tx == (tb_owner == AXI ? axi_tx : udma_tx))
        else begin
            errors++;
            $display("error %0t phy_tx_o expected %h got %h", $time,
                     (tb_owner == AXI ? axi_tx : udma_tx), phy_tx);
        end
    a_rx_valid: assert property (@(posedge clk_phy) disable iff (rst)
        tb_busy |-> (tb_owner == AXI ? axi_rx_valid : udma_rx_valid) == phy_rx_valid)
        else begin
            errors++;
            $display("error %0t %s expected %b got %b", $time,
                     (tb_owner == AXI ? "axi_rx_valid_o" : "udma_rx_valid_o"), phy_rx_valid,
                     (tb_owner == AXI ? axi_rx_valid : udma_rx_valid));
        end
    a_rx_data: assert property (@(posedge clk_phy) disable iff (rst)
        (tb_busy && phy_rx_valid) |-> (tb_owner == AXI ? axi_rx : udma_rx) == phy_rx)
        else begin
            errors++;
            $display("error %0t %s expected %h got %h", $time,
                     (tb_owner == AXI ? "axi_rx_o" : "udma_rx_o"), phy_rx,
                     (tb_owner == AXI ? axi_rx : udma_rx));
        end
    a_rx_ready: assert property (@(posedge clk_phy) disable iff (rst)
        tb_busy |-> phy_rx_ready == (tb_owner == AXI ? axi_rx_ready : udma_rx_ready))
        else begin
            errors++;
            $display("error %0t phy_rx_ready_o expected %b got %b", $time,
                     (tb_owner == AXI ? axi_rx_ready : udma_rx_ready), phy_rx_ready);
        end
    a_axi_owned: assert property (@(posedge clk_phy) disable iff (rst)
        (tb_busy && tb_owner == AXI) |-> !udma_trans_ready && !udma_tx_ready && !udma_rx_valid)
        else begin
            errors++;
            $display("uDMA saw ready or read data while AXI owned the PHY at %0t", $time);
        end
    a_udma_owned: assert property (@(posedge clk_phy) disable iff (rst)
        (tb_busy && tb_owner == UDMA)
            |-> !axi_trans_ready && !axi_tx_ready && !axi_b_valid && phy_b_ready)
        else begin
            errors++;
            $display("AXI saw ready or a write response while uDMA owned the PHY at %0t",
                     $time);
        end
    a_b_valid: assert property (@(posedge clk_phy) disable iff (rst)
        axi_b_valid == (tb_busy && tb_owner == AXI && phy_b_valid))
        else begin
            errors++;
            $display("error %0t axi_b_valid_o expected %b got %b", $time,
                     (tb_busy && tb_owner == AXI && phy_b_valid), axi_b_valid);
        end
    a_b_error: assert property (@(posedge clk_phy) disable iff (rst)
        axi_b_valid |-> axi_b_error == phy_b_error)
        else begin
            errors++;
            $display("error %0t axi_b_error_o expected %b got %b", $time,
                     phy_b_error, axi_b_error);
        end
    a_tie: assert property (@(posedge clk_phy) disable iff (rst)
        (!tb_busy && axi_trans_valid && udma_trans_valid && phy_trans_ready)
            |-> axi_trans_ready == (last_win == UDMA))
        else begin
            errors++;
            $display("error %0t axi_trans_ready_o expected %b got %b", $time,
                     (last_win == UDMA), axi_trans_ready);
        end
    a_rx_hold: assert property (@(posedge clk_phy) disable iff (rst)
        (tb_busy && tb_owner == AXI && axi_rx_valid && !axi_rx_ready)
            |=> (axi_rx_valid && axi_rx == $past(axi_rx)))
        else begin
            errors++;
            $display("error %0t axi_rx_o expected %h got %h", $time, $past(axi_rx), axi_rx);
        end

    task automatic abort_run(input string what);
        $display("timeout waiting for %s at %0t", what, $time);
        $display("test failed");
        $finish;
    endtask

    task automatic start_desc(input hyper_share_pkg::owner_e o, input logic wr,
                              input logic [15:0] burst);
        hyper_share_pkg::trans_t d;
        logic [31:0] a;
        take_bits(32, a);
        d.trans.write   = wr;
        d.trans.address = a;
        d.trans.burst   = burst;
        d.cs            = (o == AXI) ? 2'b01 : 2'b10;
        if (o == AXI) begin
            exp_axi_d       = d;
            axi_trans       = d;
            axi_trans_valid = 1'b1;
        end else begin
            exp_udma_d       = d;
            udma_trans       = d;
            udma_trans_valid = 1'b1;
        end
    endtask

    // Waits for either master's descriptor to be taken
    task automatic wait_accept();
        int n;
        for (n = 0; n < 100 && !axi_tf_q && !udma_tf_q; n++) begin
            @(negedge clk_phy);
        end
        if (!axi_tf_q && !udma_tf_q) begin
            abort_run("descriptor accept");
        end else begin
            if (axi_tf_q) begin
                axi_trans_valid = 1'b0;
            end
            if (udma_tf_q) begin
                udma_trans_valid = 1'b0;
            end
        end
    endtask

    task automatic send_beats(input hyper_share_pkg::owner_e o, input int burst);
        hyper_share_pkg::hyper_tx_t t;
        logic [31:0] v;
        int b;
        int n;
        for (b = 0; b < burst; b++) begin
            take_bits(16, v);
            t.data = v[15:0];
            t.last = (b == burst - 1);
            t.strb = 2'b11;
            if (o == AXI) begin
                axi_tx       = t;
                axi_tx_valid = 1'b1;
            end else begin
                udma_tx       = t;
                udma_tx_valid = 1'b1;
            end
            @(negedge clk_phy);
            for (n = 0; n < 100 && !(o == AXI ? axi_txf_q : udma_txf_q); n++) begin
                @(negedge clk_phy);
            end
            if (!(o == AXI ? axi_txf_q : udma_txf_q)) begin
                abort_run("write beat");
            end
        end
        axi_tx_valid  = 1'b0;
        udma_tx_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        for (n = 0; n < 200 && tb_busy; n++) begin
            @(negedge clk_phy);
        end
        if (tb_busy) begin
            abort_run("end of transfer");
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e;
        int n;
        clk_phy = 1'b0;
        rst = 1'b1;
        lfsr_q = 32'h2a3f;
        rnd = '0;
        errors = 0;
        tests = 0;
        axi_trans = '0;
        axi_trans_valid = 1'b0;
        axi_tx = '0;
        axi_tx_valid = 1'b0;
        axi_rx_ready = 1'b1;
        axi_b_ready = 1'b1;
        udma_trans = '0;
        udma_trans_valid = 1'b0;
        udma_tx = '0;
        udma_tx_valid = 1'b0;
        udma_rx_ready = 1'b1;
        exp_axi_d = '0;
        exp_udma_d = '0;
        repeat (4) @(negedge clk_phy);
        rst = 1'b0;
        @(negedge clk_phy);

        // First tie after reset, then the winner asks again at once
        // so the next start is a tie with the other master due
        e = errors;
        start_desc(AXI, 1'b0, 16'd2);
        start_desc(UDMA, 1'b0, 16'd2);
        for (n = 0; n < 4; n++) begin
            wait_accept();
            if (n < 2) begin
                if (!axi_trans_valid) begin
                    start_desc(AXI, 1'b0, 16'd2);
                end else begin
                    start_desc(UDMA, 1'b0, 16'd2);
                end
            end
            wait_idle();
        end
        finish_test("tie and hold-off", e);

        e = errors;
        start_desc(AXI, 1'b0, 16'd4);
        wait_accept();
        wait_idle();
        finish_test("axi read", e);

        e = errors;
        start_desc(UDMA, 1'b1, 16'd3);
        wait_accept();
        send_beats(UDMA, 3);
        wait_idle();
        finish_test("udma write", e);

        // Repeat until the model has answered once with the error bit set
        e = errors;
        for (n = 0; n < 8 && !b_err_seen; n++) begin
            start_desc(AXI, 1'b1, 16'd2);
            wait_accept();
            send_beats(AXI, 2);
            wait_idle();
        end
        if (!b_err_seen) begin
            errors++;
            $display("no AXI write response carried the error bit");
        end
        finish_test("axi write", e);

        e = errors;
        start_desc(AXI, 1'b0, 16'd3);
        axi_rx_ready = 1'b0;
        wait_accept();
        for (n = 0; n < 3; n++) begin
            @(negedge clk_phy);
        end
        axi_rx_ready = 1'b1;
        wait_idle();
        finish_test("rx back-pressure", e);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hyper_share_pkg.sv
hyper_owner_arbiter.sv
hyper_request_mux.sv
hyper_response_route.sv
hyper_phy_share.sv
tb_phy_model.sv
tb_hyper_phy_share.sv
